// File: kotku_fabric.f
+incdir+testbench
hdl/kotku_pkg.sv
hdl/reset_debounce.sv
hdl/bus_switch.sv
hdl/gpio_regs.sv
hdl/simple_pic.sv
hdl/interval_timer.sv
hdl/kotku_fabric.sv
testbench/tb_kotku_fabric.sv

// File: run.sh
#!/bin/sh
# Compile the fabric testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_kotku_fabric \
  -f kotku_fabric.f && ./obj_dir/Vtb_kotku_fabric > sim.log 2>&1
status=$?
[ -f sim.log ] && cat sim.log
[ "$status" -eq 0 ] || { echo "Build or simulation error"; exit 1; }
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: testbench/tb_util.svh
/* Testbench helpers
   Random source, value compare and bounded waits on DUT outputs */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

localparam int ACK_LIMIT  = 32;
localparam int WAIT_LIMIT = 64;

logic [31:0] lfsr_state = 32'h5531;
int          errors     = 0;
int          checks     = 0;

// Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// Byte lanes of new_w replace old_w where sel is set
function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
                                            input logic [15:0] new_w,
                                            input logic [1:0]  sel);
  logic [15:0] w;
  w = old_w;
  if (sel[0]) w[7:0] = new_w[7:0];
  if (sel[1]) w[15:8] = new_w[15:8];
  return w;
endfunction

task automatic compare_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic wait_ack();
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!m_ack_o && n < ACK_LIMIT);
  if (!m_ack_o) begin
    errors++;
    $display("Bus cycle at %0t ns never received an ack", $time);
  end
endtask

task automatic wait_intr(input logic level);
  int n;
  n = 0;
  while (intr_o !== level && n < WAIT_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (intr_o !== level) begin
    errors++;
    $display("Timed out at %0t ns waiting for intr_o to become %b", $time, level);
  end
endtask

task automatic wait_nmi(input logic level);
  int n;
  n = 0;
  while (nmi_o !== level && n < WAIT_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (nmi_o !== level) begin
    errors++;
    $display("Timed out at %0t ns waiting for nmi_o to become %b", $time, level);
  end
endtask

`endif

// File: testbench/tb_kotku_fabric.sv
/* Kotku fabric testbench
   Random master cycles against a RAM model, GPIO, timer, PIC and NMI checks */
`timescale 1ns/1ns

module tb_kotku_fabric;
  import kotku_pkg::*;

  logic                clk = 1'b0;
  logic                rst_lck;
  logic [DATA_W-1:0]   m_dat_i;
  logic [ADDR_W-1:1]   m_adr_i;
  logic                m_tga_i;
  logic [SEL_W-1:0]    m_sel_i;
  logic                m_we_i;
  logic                m_cyc_i;
  logic                m_stb_i;
  logic [DATA_W-1:0]   m_dat_o;
  logic                m_ack_o;
  logic                inta_i;
  logic                nmia_i;
  logic [ADDR_W-1:1]   ram_adr_o;
  logic [DATA_W-1:0]   ram_dat_o;
  logic [SEL_W-1:0]    ram_sel_o;
  logic                ram_we_o;
  logic                ram_stb_o;
  logic [DATA_W-1:0]   ram_dat_i = '0;
  logic                ram_ack_i = 1'b0;
  logic [7:0]          sw_i;
  logic                key_i;
  logic [NUM_IRQ-1:1]  irq_ext_i;
  logic [DATA_W-1:0]   leds_o;
  logic                intr_o;
  logic                nmi_o;

  // RAM model state, last access kept for checking
  logic [15:0] ram_mem [logic [18:0]];
  logic [1:0]  ram_wait = 2'd0;
  logic [15:0] ram_word;
  logic [18:0] last_adr;
  logic [1:0]  last_sel;
  logic        last_we;
  logic [15:0] last_dat;

  // Stimulus state
  logic [18:0] pool [8];
  logic [15:0] exp_mem [8];
  logic [15:0] exp_leds;
  logic [15:0] wdat;
  logic [15:0] rdat;
  logic [1:0]  sel;
  logic [2:0]  idx;
  logic        we;

  `include "tb_util.svh"

  always #2 clk = ~clk;

  kotku_fabric dut (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .m_dat_i   (m_dat_i),
    .m_adr_i   (m_adr_i),
    .m_tga_i   (m_tga_i),
    .m_sel_i   (m_sel_i),
    .m_we_i    (m_we_i),
    .m_cyc_i   (m_cyc_i),
    .m_stb_i   (m_stb_i),
    .m_dat_o   (m_dat_o),
    .m_ack_o   (m_ack_o),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .ram_adr_o (ram_adr_o),
    .ram_dat_o (ram_dat_o),
    .ram_sel_o (ram_sel_o),
    .ram_we_o  (ram_we_o),
    .ram_stb_o (ram_stb_o),
    .ram_dat_i (ram_dat_i),
    .ram_ack_i (ram_ack_i),
    .sw_i      (sw_i),
    .key_i     (key_i),
    .irq_ext_i (irq_ext_i),
    .leds_o    (leds_o),
    .intr_o    (intr_o),
    .nmi_o     (nmi_o)
  );

  // Unwritten words read back a pattern of the whole address
  function automatic logic [15:0] fill_word(input logic [18:0] a);
    return a[15:0] ^ {a[18:16], 13'h0};
  endfunction

  function automatic logic [ADDR_W-1:1] io_addr(input logic [15:0] port);
    bus_addr_u a;
    a         = '0;
    a.io.tag  = 1'b1;
    a.io.port = port[15:1];
    return a[ADDR_W-2:0];
  endfunction

  // Base RAM with 0 to 3 random wait cycles
  always @(posedge clk) begin
    ram_ack_i <= 1'b0;
    if (ram_stb_o && !ram_ack_i) begin
      if (ram_wait != 2'd0) begin
        ram_wait <= ram_wait - 2'd1;
      end else begin
        last_adr = ram_adr_o;
        last_sel = ram_sel_o;
        last_we  = ram_we_o;
        last_dat = ram_dat_o;
        ram_word = ram_mem.exists(ram_adr_o) ? ram_mem[ram_adr_o] : fill_word(ram_adr_o);
        if (ram_we_o) begin
          ram_word = merge_bytes(ram_word, ram_dat_o, ram_sel_o);
          ram_mem[ram_adr_o] = ram_word;
        end
        ram_dat_i <= ram_word;
        ram_ack_i <= 1'b1;
        ram_wait  <= 2'(rand_bits(2));
      end
    end
  end

  task automatic bus_cycle(input logic io, input logic [ADDR_W-1:1] adr, input logic wr,
                           input logic [1:0] bsel, input logic [15:0] dat,
                           output logic [15:0] rd);
    @(negedge clk);
    m_tga_i = io;
    m_adr_i = adr;
    m_we_i  = wr;
    m_sel_i = bsel;
    m_dat_i = dat;
    m_cyc_i = 1'b1;
    m_stb_i = 1'b1;
    wait_ack();
    rd      = m_dat_o;  // Valid with ack
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    m_we_i  = 1'b0;
  endtask

  // Interrupt or NMI acknowledge, returns the vector word
  task automatic ack_cycle(input logic nmi, output logic [15:0] vec);
    @(negedge clk);
    if (nmi) begin
      nmia_i = 1'b1;
    end else begin
      inta_i = 1'b1;
    end
    @(negedge clk);
    vec    = m_dat_o;
    inta_i = 1'b0;
    nmia_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic ram_access_check(input logic [18:0] adr, input logic wr,
                                  input logic [1:0] bsel, input logic [15:0] dat);
    compare_word("ram_adr_o", 32'(last_adr), 32'(adr));
    compare_word("ram_we_o", 32'(last_we), 32'(wr));
    compare_word("ram_sel_o", 32'(last_sel), 32'(bsel));
    if (wr) compare_word("ram_dat_o", 32'(last_dat), 32'(dat));
  endtask

  initial begin
    rst_lck   = 1'b0;
    m_dat_i   = '0;
    m_adr_i   = '0;
    m_tga_i   = 1'b0;
    m_sel_i   = '0;
    m_we_i    = 1'b0;
    m_cyc_i   = 1'b0;
    m_stb_i   = 1'b0;
    inta_i    = 1'b0;
    nmia_i    = 1'b0;
    sw_i      = '0;
    key_i     = 1'b1;  // Button released
    irq_ext_i = '0;
    repeat (16) @(negedge clk);
    rst_lck = 1'b1;
    repeat (RST_HOLD + 2) @(negedge clk);

    compare_word("leds_o", 32'(leds_o), 32'h0);
    compare_word("intr_o", 32'(intr_o), 32'h0);
    compare_word("nmi_o", 32'(nmi_o), 32'h0);
    bus_cycle(1'b1, io_addr(GPIO_PORT + 16'd2), 1'b0, 2'b11, 16'h0, rdat);
    compare_word("led readback", 32'(rdat), 32'h0);

    // Fill distinct RAM words, then random traffic on them
    for (int i = 0; i < 8; i++) begin
      pool[i] = {16'(rand_bits(16)), 3'(i)};
      wdat    = 16'(rand_bits(16));
      bus_cycle(1'b0, pool[i], 1'b1, 2'b11, wdat, rdat);
      exp_mem[i] = wdat;
      ram_access_check(pool[i], 1'b1, 2'b11, wdat);
    end
    for (int n = 0; n < 48; n++) begin
      idx  = 3'(rand_bits(3));
      we   = 1'(rand_bits(1));
      sel  = 2'(rand_bits(2));
      wdat = 16'(rand_bits(16));
      bus_cycle(1'b0, pool[idx], we, sel, wdat, rdat);
      ram_access_check(pool[idx], we, sel, wdat);
      if (we) begin
        exp_mem[idx] = merge_bytes(exp_mem[idx], wdat, sel);
      end else begin
        compare_word("ram read data", 32'(rdat), 32'(exp_mem[idx]));
      end
    end

    exp_leds = '0;
    for (int n = 0; n < 12; n++) begin
      sel  = 2'(rand_bits(2));
      wdat = 16'(rand_bits(16));
      bus_cycle(1'b1, io_addr(GPIO_PORT + 16'd2), 1'b1, sel, wdat, rdat);
      exp_leds = merge_bytes(exp_leds, wdat, sel);
      compare_word("leds_o", 32'(leds_o), 32'(exp_leds));
      bus_cycle(1'b1, io_addr(GPIO_PORT + 16'd2), 1'b0, 2'b11, 16'h0, rdat);
      compare_word("led readback", 32'(rdat), 32'(exp_leds));
      sw_i = 8'(rand_bits(8));
      bus_cycle(1'b1, io_addr(GPIO_PORT), 1'b0, 2'b11, 16'h0, rdat);
      compare_word("switch read", 32'(rdat), 32'(sw_i));
    end

    bus_cycle(1'b1, io_addr(16'h03F8), 1'b0, 2'b11, 16'h0, rdat);
    compare_word("unmapped read", 32'(rdat), 32'h0);

    // Timer on line 0 with a short reload
    bus_cycle(1'b1, io_addr(TIMER_PORT), 1'b1, 2'b11, 16'(4 + rand_bits(3)), rdat);
    bus_cycle(1'b1, io_addr(TIMER_PORT + 16'd2), 1'b1, 2'b01, 16'h0001, rdat);
    wait_intr(1'b1);
    ack_cycle(1'b0, rdat);
    compare_word("timer vector", 32'(rdat), 32'(IRQ_VEC_BASE));
    bus_cycle(1'b1, io_addr(TIMER_PORT + 16'd2), 1'b1, 2'b01, 16'h0000, rdat);
    repeat (4) @(negedge clk);
    for (int n = 0; n < 8 && intr_o; n++) begin
      ack_cycle(1'b0, rdat);  // Drain late timer requests
    end
    compare_word("intr_o", 32'(intr_o), 32'h0);

    @(negedge clk);
    irq_ext_i[3] = 1'b1;
    irq_ext_i[5] = 1'b1;
    wait_intr(1'b1);
    ack_cycle(1'b0, rdat);
    compare_word("irq3 vector", 32'(rdat), 32'(IRQ_VEC_BASE + 3));
    ack_cycle(1'b0, rdat);
    compare_word("irq5 vector", 32'(rdat), 32'(IRQ_VEC_BASE + 5));
    compare_word("intr_o", 32'(intr_o), 32'h0);
    irq_ext_i = '0;

    @(negedge clk);
    key_i = 1'b0;  // Press
    wait_nmi(1'b1);
    ack_cycle(1'b1, rdat);
    compare_word("nmi vector", 32'(rdat), 32'(NMI_VEC));
    compare_word("nmi_o", 32'(nmi_o), 32'h0);
    key_i = 1'b1;
    repeat (4) @(negedge clk);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/kotku_fabric.sv
/* Kotku CPU side bus fabric
   Decoder, GPIO, timer, interrupt controller and reset stretcher */
`timescale 1ns/1ns

module kotku_fabric (
  input  logic                          clk,
  input  logic                          rst_lck,
  input  logic [kotku_pkg::DATA_W-1:0]  m_dat_i,
  input  logic [kotku_pkg::ADDR_W-1:1]  m_adr_i,
  input  logic                          m_tga_i,
  input  logic [kotku_pkg::SEL_W-1:0]   m_sel_i,
  input  logic                          m_we_i,
  input  logic                          m_cyc_i,
  input  logic                          m_stb_i,
  output logic [kotku_pkg::DATA_W-1:0]  m_dat_o,
  output logic                          m_ack_o,
  input  logic                          inta_i,
  input  logic                          nmia_i,
  output logic [kotku_pkg::ADDR_W-1:1]  ram_adr_o,
  output logic [kotku_pkg::DATA_W-1:0]  ram_dat_o,
  output logic [kotku_pkg::SEL_W-1:0]   ram_sel_o,
  output logic                          ram_we_o,
  output logic                          ram_stb_o,
  input  logic [kotku_pkg::DATA_W-1:0]  ram_dat_i,
  input  logic                          ram_ack_i,
  input  logic [7:0]                    sw_i,
  input  logic                          key_i,
  input  logic [kotku_pkg::NUM_IRQ-1:1] irq_ext_i,
  output logic [kotku_pkg::DATA_W-1:0]  leds_o,
  output logic                          intr_o,
  output logic                          nmi_o
);
  import kotku_pkg::*;

  logic              rst;
  logic [DATA_W-1:0] s_dat;
  logic              s_adr;
  logic [SEL_W-1:0]  s_sel;
  logic              s_we;
  logic              gpio_stb;
  logic              timer_stb;
  logic [DATA_W-1:0] gpio_dat;
  logic [DATA_W-1:0] timer_dat;
  logic              gpio_ack;
  logic              timer_ack;
  logic              timer_irq;
  logic [IID_W-1:0]  iid;

  // Base RAM shares the slave write side
  assign ram_dat_o = s_dat;
  assign ram_sel_o = s_sel;
  assign ram_we_o  = s_we;

  reset_debounce u_rst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst)
  );

  bus_switch u_switch (
    .clk         (clk),
    .rst_i       (rst),
    .m_dat_i     (m_dat_i),
    .m_adr_i     (m_adr_i),
    .m_tga_i     (m_tga_i),
    .m_sel_i     (m_sel_i),
    .m_we_i      (m_we_i),
    .m_cyc_i     (m_cyc_i),
    .m_stb_i     (m_stb_i),
    .m_dat_o     (m_dat_o),
    .m_ack_o     (m_ack_o),
    .inta_i      (inta_i),
    .nmia_i      (nmia_i),
    .iid_i       (iid),
    .s_dat_o     (s_dat),
    .s_adr_o     (s_adr),
    .s_sel_o     (s_sel),
    .s_we_o      (s_we),
    .gpio_stb_o  (gpio_stb),
    .timer_stb_o (timer_stb),
    .ram_stb_o   (ram_stb_o),
    .gpio_dat_i  (gpio_dat),
    .timer_dat_i (timer_dat),
    .ram_dat_i   (ram_dat_i),
    .gpio_ack_i  (gpio_ack),
    .timer_ack_i (timer_ack),
    .ram_ack_i   (ram_ack_i),
    .ram_adr_o   (ram_adr_o)
  );

  gpio_regs u_gpio (
    .clk    (clk),
    .rst_i  (rst),
    .stb_i  (gpio_stb),
    .we_i   (s_we),
    .adr_i  (s_adr),
    .sel_i  (s_sel),
    .dat_i  (s_dat),
    .sw_i   (sw_i),
    .key_i  (key_i),
    .nmia_i (nmia_i),
    .dat_o  (gpio_dat),
    .ack_o  (gpio_ack),
    .leds_o (leds_o),
    .nmi_o  (nmi_o)
  );

  interval_timer u_timer (
    .clk   (clk),
    .rst_i (rst),
    .stb_i (timer_stb),
    .we_i  (s_we),
    .adr_i (s_adr),
    .sel_i (s_sel),
    .dat_i (s_dat),
    .dat_o (timer_dat),
    .ack_o (timer_ack),
    .irq_o (timer_irq)
  );

  simple_pic u_pic (
    .clk    (clk),
    .rst_i  (rst),
    .irq_i  ({irq_ext_i, timer_irq}),  // Timer on line 0
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

endmodule

// File: hdl/interval_timer.sv
/* Interval timer
   Reloadable down counter that pulses an interrupt when it wraps */
`timescale 1ns/1ns

module interval_timer (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic                         adr_i,
  input  logic [kotku_pkg::SEL_W-1:0]  sel_i,
  input  logic [kotku_pkg::DATA_W-1:0] dat_i,
  output logic [kotku_pkg::DATA_W-1:0] dat_o,
  output logic                         ack_o,
  output logic                         irq_o
);
  import kotku_pkg::*;

  logic              access;
  logic              wr_reload;
  logic              enable;
  logic [DATA_W-1:0] reload;
  logic [DATA_W-1:0] reload_wr;
  logic [DATA_W-1:0] count;

  assign access    = stb_i & ~ack_o;
  assign wr_reload = access & we_i & ~adr_i;

  // Byte merge for reload writes
  always_comb begin
    reload_wr = reload;
    for (int i = 0; i < SEL_W; i++) begin
      if (sel_i[i]) reload_wr[8*i +: 8] = dat_i[8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o  <= 1'b0;
      irq_o  <= 1'b0;
      enable <= 1'b0;
      reload <= '0;
      count  <= '0;
    end else begin
      ack_o <= access;
      irq_o <= 1'b0;
      if (access && we_i && adr_i && sel_i[0]) enable <= dat_i[0];
      if (wr_reload) begin
        reload <= reload_wr;
        count  <= reload_wr;  // Restart from the new value
      end else if (enable) begin
        if (count == '0) begin
          count <= reload;
          irq_o <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) dat_o <= adr_i ? {{(DATA_W-1){1'b0}}, enable} : count;
  end

endmodule

// File: hdl/simple_pic.sv
/* Eight line priority interrupt controller
   Edge triggered, lowest line wins, cleared on interrupt acknowledge */
`timescale 1ns/1ns

module simple_pic (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic [kotku_pkg::NUM_IRQ-1:0] irq_i,
  input  logic                          inta_i,
  output logic                          intr_o,
  output logic [kotku_pkg::IID_W-1:0]   iid_o
);
  import kotku_pkg::*;

  logic [NUM_IRQ-1:0] irq_q;
  logic [NUM_IRQ-1:0] pending;
  logic [NUM_IRQ-1:0] clr_mask;
  logic [NUM_IRQ-1:0] kept;
  logic               inta_q;
  logic               inta_rise;

  // Lowest numbered set bit
  function automatic logic [IID_W-1:0] lowest(input logic [NUM_IRQ-1:0] bits);
    logic [IID_W-1:0] idx;
    idx = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (bits[i]) idx = IID_W'(i);
    end
    return idx;
  endfunction

  assign inta_rise = inta_i & ~inta_q;
  assign clr_mask  = inta_rise ? (NUM_IRQ'(1) << iid_o) : '0;
  assign kept      = pending & ~clr_mask;  // Pending minus the acked line

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q   <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
      intr_o  <= 1'b0;
      iid_o   <= '0;
    end else begin
      irq_q   <= irq_i;
      inta_q  <= inta_i;
      pending <= kept | (irq_i & ~irq_q);  // New edges win over a clear
      intr_o  <= |kept;
      if (!inta_i) iid_o <= lowest(pending);  // Held through the ack
    end
  end

  // intr_o lags pending, so a stale request would show up here
  a_intr_has_pending: assert property (@(posedge clk) disable iff (rst_i)
    intr_o |-> (pending != '0));

endmodule

// File: hdl/gpio_regs.sv
/* Switch and LED registers with pushbutton NMI
   Register 0 reads the switches, register 1 holds the LEDs */
`timescale 1ns/1ns

module gpio_regs (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic                         adr_i,
  input  logic [kotku_pkg::SEL_W-1:0]  sel_i,
  input  logic [kotku_pkg::DATA_W-1:0] dat_i,
  input  logic [7:0]                   sw_i,
  input  logic                         key_i,
  input  logic                         nmia_i,
  output logic [kotku_pkg::DATA_W-1:0] dat_o,
  output logic                         ack_o,
  output logic [kotku_pkg::DATA_W-1:0] leds_o,
  output logic                         nmi_o
);
  import kotku_pkg::*;

  logic       access;
  logic [2:0] key_q;  // Two sync stages, then edge history
  logic       key_fall;

  assign access   = stb_i & ~ack_o;  // First cycle of a strobe
  assign key_fall = key_q[2] & ~key_q[1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o  <= 1'b0;
      leds_o <= '0;
    end else begin
      ack_o <= access;
      if (access && we_i && adr_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (sel_i[i]) leds_o[8*i +: 8] <= dat_i[8*i +: 8];
        end
      end
    end
  end

  // Read data is valid with ack
  always_ff @(posedge clk) begin
    if (access) dat_o <= adr_i ? leds_o : {{(DATA_W-8){1'b0}}, sw_i};
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      key_q <= '1;  // Pushbutton idles high
      nmi_o <= 1'b0;
    end else begin
      key_q <= {key_q[1:0], key_i};
      if (key_fall) begin
        nmi_o <= 1'b1;
      end else if (nmia_i) begin
        nmi_o <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/bus_switch.sv
/* CPU bus address decoder
   Routes strobes to GPIO, timer, base RAM or the default responder,
   and returns ack and read data, with vector words on acknowledge cycles */
`timescale 1ns/1ns

module bus_switch (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic [kotku_pkg::DATA_W-1:0]  m_dat_i,
  input  logic [kotku_pkg::ADDR_W-1:1]  m_adr_i,
  input  logic                          m_tga_i,
  input  logic [kotku_pkg::SEL_W-1:0]   m_sel_i,
  input  logic                          m_we_i,
  input  logic                          m_cyc_i,
  input  logic                          m_stb_i,
  output logic [kotku_pkg::DATA_W-1:0]  m_dat_o,
  output logic                          m_ack_o,
  input  logic                          inta_i,
  input  logic                          nmia_i,
  input  logic [kotku_pkg::IID_W-1:0]   iid_i,
  output logic [kotku_pkg::DATA_W-1:0]  s_dat_o,
  output logic                          s_adr_o,
  output logic [kotku_pkg::SEL_W-1:0]   s_sel_o,
  output logic                          s_we_o,
  output logic                          gpio_stb_o,
  output logic                          timer_stb_o,
  output logic                          ram_stb_o,
  input  logic [kotku_pkg::DATA_W-1:0]  gpio_dat_i,
  input  logic [kotku_pkg::DATA_W-1:0]  timer_dat_i,
  input  logic [kotku_pkg::DATA_W-1:0]  ram_dat_i,
  input  logic                          gpio_ack_i,
  input  logic                          timer_ack_i,
  input  logic                          ram_ack_i,
  output logic [kotku_pkg::ADDR_W-1:1]  ram_adr_o
);
  import kotku_pkg::*;

  bus_addr_u         addr;
  logic              cyc_stb;
  logic              gpio_hit;
  logic              timer_hit;
  logic              ram_hit;
  logic              def_stb;
  logic [DATA_W-1:0] bus_dat;
  logic [DATA_W-1:0] vec_dat;

  assign addr    = {m_tga_i, m_adr_i};
  assign cyc_stb = m_cyc_i & m_stb_i;

  // First match wins: GPIO, timer, any memory address, default
  assign gpio_hit  = addr.io.tag && ((addr.io.port & GPIO_MASK[15:1]) == GPIO_PORT[15:1]);
  assign timer_hit = addr.io.tag && !gpio_hit
                     && ((addr.io.port & TIMER_MASK[15:1]) == TIMER_PORT[15:1]);
  assign ram_hit   = !addr.mem.tag;

  assign gpio_stb_o  = cyc_stb & gpio_hit;
  assign timer_stb_o = cyc_stb & timer_hit;
  assign ram_stb_o   = cyc_stb & ram_hit;
  assign def_stb     = cyc_stb & !(gpio_hit | timer_hit | ram_hit);

  // Shared slave side
  assign s_dat_o   = m_dat_i;
  assign s_adr_o   = m_adr_i[1];  // Register select
  assign s_sel_o   = m_sel_i;
  assign s_we_o    = m_we_i;
  assign ram_adr_o = addr.mem.word;

  // Unmapped cycles end at once
  assign m_ack_o = (gpio_stb_o & gpio_ack_i)
                 | (timer_stb_o & timer_ack_i)
                 | (ram_stb_o & ram_ack_i)
                 | def_stb;

  always_comb begin
    if (gpio_hit) begin
      bus_dat = gpio_dat_i;
    end else if (timer_hit) begin
      bus_dat = timer_dat_i;
    end else if (ram_hit) begin
      bus_dat = ram_dat_i;
    end else begin
      bus_dat = '0;  // Default responder reads zero
    end
  end

  assign vec_dat = DATA_W'(IRQ_VEC_BASE) + DATA_W'(iid_i);
  assign m_dat_o = nmia_i ? NMI_VEC : (inta_i ? vec_dat : bus_dat);  // NMI first

  a_one_target: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0({gpio_stb_o, timer_stb_o, ram_stb_o, def_stb}));

endmodule

// File: hdl/reset_debounce.sv
/* Reset stretcher
   Keeps the fabric in reset for a fixed number of cycles after release */
`timescale 1ns/1ns

module reset_debounce (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_o
);
  import kotku_pkg::*;

  localparam int CNT_W = $clog2(RST_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_cnt <= CNT_W'(RST_HOLD);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign rst_o = (hold_cnt != '0);  // Released once drained

  // Reset drops only with rst_lck high, and high for the full hold time
  a_hold_in_reset: assert property (@(posedge clk)
    $fell(rst_o) |-> rst_lck && $past(rst_lck, RST_HOLD));

endmodule

// File: hdl/kotku_pkg.sv
/* Kotku bus fabric shared definitions
   Bus widths, I/O map, reset hold length and the decoded bus address */
package kotku_pkg;

  localparam int DATA_W   = 16;
  localparam int ADDR_W   = 20;  // I/O tag + word address 19..1
  localparam int SEL_W    = 2;
  localparam int NUM_IRQ  = 8;
  localparam int IID_W    = 3;
  localparam int RST_HOLD = 32;  // Cycles of reset after release

  // I/O ports are byte addresses, masks keep the compared bits
  localparam logic [15:0] GPIO_PORT  = 16'hF100;
  localparam logic [15:0] GPIO_MASK  = 16'hFFFC;  // 0xF100 - 0xF103
  localparam logic [15:0] TIMER_PORT = 16'h0040;
  localparam logic [15:0] TIMER_MASK = 16'hFFFC;  // 0x40 - 0x43

  // Words returned on acknowledge cycles
  localparam int                IRQ_VEC_BASE = 8;
  localparam logic [DATA_W-1:0] NMI_VEC      = 16'h0002;

  // Tag and word address, seen as memory or as an I/O port
  typedef union packed {
    struct packed {
      logic              tag;   // 0 for memory
      logic [ADDR_W-2:0] word;  // Address bits 19..1
    } mem;
    struct packed {
      logic               tag;    // 1 for I/O
      logic [ADDR_W-17:0] spare;
      logic [14:0]        port;   // Port bits 15..1
    } io;
  } bus_addr_u;

endpackage
